//--- Makefile
# Verilator flow for the branch predictor
# make lint | make sim | make clean

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_bpu
RTL_TOP   ?= bpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -sv --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint lint_rtl lint_tb sim build clean

all: sim

lint: lint_rtl lint_tb

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

lint_tb:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

# pass only when the log holds the pass line
sim: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+.
bp_pkg.sv
bht_if.sv
bht_table.sv
branch_lookup.sv
branch_resolve.sv
bpu_top.sv
tb_bpu.sv

//--- bht_if.sv
//******************************
// bht access bundle
// lookup read, resolve read, write port
//******************************
`default_nettype none
`timescale 1ns/1ps
`include "bp_cfg.svh"

interface bht_if import bp_pkg::*; ();

    // fetch side read
    logic [`BP_IDX_W-1:0] lk_index;
    bht_entry_t           lk_entry;

    // execute side read
    logic [`BP_IDX_W-1:0] rs_index;
    bht_entry_t           rs_entry;

    // single write port, owned by resolve
    logic                 wr_en;
    logic [`BP_IDX_W-1:0] wr_index;
    ctr_t                 wr_ctr; // valid is implied on every write

    // table side
    modport tbl (
        input  lk_index, rs_index,
        input  wr_en, wr_index, wr_ctr,
        output lk_entry, rs_entry
    );

    modport lookup (
        output lk_index,
        input  lk_entry
    );

    modport resolve (
        output rs_index, wr_en, wr_index, wr_ctr,
        input  rs_entry
    );

endinterface

`default_nettype wire

//--- bht_table.sv
//******************************
// branch history table storage
// 2 comb reads, 1 clocked write
//******************************
`default_nettype none
`timescale 1ns/1ps
`include "bp_cfg.svh"

module bht_table import bp_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    bht_if.tbl    tbl
);

    // valid bits, cleared by reset
    logic [`BP_DEPTH-1:0] vld;

    // counter array, contents only meaningful when valid
    ctr_t ctr_mem [`BP_DEPTH];

    // lookup read port, async
    assign tbl.lk_entry = '{
        valid: vld[tbl.lk_index],
        ctr:   ctr_mem[tbl.lk_index]
    };

    // resolve read port, async
    // a same-edge lookup still sees the old entry here
    assign tbl.rs_entry = '{
        valid: vld[tbl.rs_index],
        ctr:   ctr_mem[tbl.rs_index]
    };

    // valid update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld <= '0; // whole table invalid
        end else if (tbl.wr_en) begin
            vld[tbl.wr_index] <= 1'b1; // any write allocates
        end
    end

    // counter update
    always_ff @(posedge clk) begin
        if (tbl.wr_en) begin
            ctr_mem[tbl.wr_index] <= tbl.wr_ctr;
        end
    end

endmodule

`default_nettype wire

//--- bp_cfg.svh
//******************************
// branch predictor sizing macros
// pc width, bht index width, depth
//******************************
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// fetch and execute side pc width
`define BP_PC_W 32

// bht index width, taken from pc[BP_IDX_W+1:2]
`define BP_IDX_W 8

// number of bht entries
`define BP_DEPTH (1 << `BP_IDX_W)

`endif

//--- bp_pkg.sv
//******************************
// branch predictor types
// 2-bit counter enum, bht entry struct
//******************************
`default_nettype none

package bp_pkg;

    // 2-bit saturating counter
    // msb is the predicted direction
    typedef enum logic [1:0] {
        ctr_strong_n = 2'b00, // N
        ctr_weak_n   = 2'b01, // n
        ctr_weak_t   = 2'b10, // t
        ctr_strong_t = 2'b11  // T
    } ctr_t;

    // one bht slot, no tag so aliasing is accepted
    typedef struct packed {
        logic valid; // set on first resolve
        ctr_t ctr;   // counter state
    } bht_entry_t;

endpackage

`default_nettype wire

//--- bpu_top.sv
//******************************
// branch predictor top
// bht, lookup and resolve wiring
//******************************
`default_nettype none
`timescale 1ns/1ps
`include "bp_cfg.svh"

module bpu_top (
    input  logic                clk,
    input  logic                rst,
    // fetch side
    input  logic                lookup,
    input  logic [`BP_PC_W-1:0] lookup_pc,
    input  logic                uncond,
    // execute side
    input  logic                resolve,
    input  logic [`BP_PC_W-1:0] resolve_pc,
    input  logic                resolve_taken,
    // prediction, one cycle after lookup
    output logic                pred_valid,
    output logic                pred_taken,
    output logic                pred_hit
);

    // shared table bus
    bht_if bht_bus ();

    // storage
    bht_table u_table (
        .clk (clk),
        .rst (rst),
        .tbl (bht_bus.tbl)
    );

    // producer, reads table on fetch
    branch_lookup u_lookup (
        .clk        (clk),
        .rst        (rst),
        .lookup     (lookup),
        .lookup_pc  (lookup_pc),
        .uncond     (uncond),
        .lk         (bht_bus.lookup),
        .pred_valid (pred_valid),
        .pred_taken (pred_taken),
        .pred_hit   (pred_hit)
    );

    // consumer, trains table on resolve
    branch_resolve u_resolve (
        .resolve       (resolve),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken),
        .rs            (bht_bus.resolve)
    );

endmodule

`default_nettype wire

//--- branch_lookup.sv
//******************************
// fetch side lookup
// index from pc, registered prediction
//******************************
`default_nettype none
`timescale 1ns/1ps
`include "bp_cfg.svh"

module branch_lookup import bp_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                lookup,    // fetch strobe
    input  logic [`BP_PC_W-1:0] lookup_pc,
    input  logic                uncond,    // jump, always taken
    bht_if.lookup               lk,
    output logic                pred_valid,
    output logic                pred_taken,
    output logic                pred_hit
);

    logic entry_hit;   // slot holds a trained counter
    logic entry_taken; // direction from the slot

    // word aligned pc, bits 1:0 dropped
    assign lk.lk_index = lookup_pc[`BP_IDX_W+1:2];

    assign entry_hit = lk.lk_entry.valid;

    // miss predicts not taken
    assign entry_taken = entry_hit & lk.lk_entry.ctr[1];

    // one cycle lookup pipe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid <= 1'b0;
            pred_taken <= 1'b0;
            pred_hit   <= 1'b0;
        end else begin
            pred_valid <= lookup; // single cycle pulse per strobe
            if (lookup) begin
                pred_hit   <= entry_hit;
                pred_taken <= uncond | entry_taken; // uncond overrides counter
            end
            // no strobe, hold last taken/hit
        end
    end

endmodule

`default_nettype wire

//--- branch_resolve.sv
//******************************
// execute side resolve
// counter training and allocation
//******************************
`default_nettype none
`timescale 1ns/1ps
`include "bp_cfg.svh"

module branch_resolve import bp_pkg::*; (
    input  logic                resolve,       // execute strobe
    input  logic [`BP_PC_W-1:0] resolve_pc,
    input  logic                resolve_taken, // actual outcome
    bht_if.resolve              rs
);

    logic [`BP_IDX_W-1:0] idx;
    ctr_t                 next_ctr;

    // same index slice as the lookup side
    assign idx = resolve_pc[`BP_IDX_W+1:2];

    assign rs.rs_index = idx;

    // next counter state
    always_comb begin
        next_ctr = rs.rs_entry.ctr;
        if (!rs.rs_entry.valid) begin
            // fresh slot, start weak in the outcome's direction
            next_ctr = resolve_taken ? ctr_weak_t : ctr_weak_n;
        end else if (resolve_taken) begin
            case (rs.rs_entry.ctr)
                ctr_strong_n: next_ctr = ctr_weak_n;
                ctr_weak_n:   next_ctr = ctr_weak_t;
                ctr_weak_t:   next_ctr = ctr_strong_t;
                default:      next_ctr = ctr_strong_t; // saturate at T
            endcase
        end else begin
            case (rs.rs_entry.ctr)
                ctr_strong_t: next_ctr = ctr_weak_t;
                ctr_weak_t:   next_ctr = ctr_weak_n;
                ctr_weak_n:   next_ctr = ctr_strong_n;
                default:      next_ctr = ctr_strong_n; // saturate at N
            endcase
        end
    end

    // write port, committed by the table at this edge
    assign rs.wr_en    = resolve;
    assign rs.wr_index = idx;
    assign rs.wr_ctr   = next_ctr;

endmodule

`default_nettype wire

//--- tb_bpu.sv
//******************************
// testbench for bpu_top
// directed table, lcg random phase,
// reference bht model, watchdog
//******************************
`default_nettype none
`timescale 1ns/1ps
`include "bp_cfg.svh"

module tb_bpu;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 2;
    localparam int NUM_ROWS   = 28;
    localparam int NUM_RAND   = 200;
    localparam int TIMEOUT_NS = (NUM_ROWS + NUM_RAND + RST_CYCLES + 10) * CLK_PERIOD;

    // directed row pcs with index pc[9:2]
    localparam logic [31:0] PC_0     = 32'h0000_0000;
    localparam logic [31:0] PC_A     = 32'h0000_0040; // idx 0x10
    localparam logic [31:0] PC_A_HI  = 32'h1234_5440; // alias of A via upper bits
    localparam logic [31:0] PC_A_LO  = 32'h0000_0043; // alias of A via bits 1:0
    localparam logic [31:0] PC_A_ALL = 32'hffff_fc41; // alias of A via both
    localparam logic [31:0] PC_B     = 32'h0000_0080; // idx 0x20
    localparam logic [31:0] PC_C     = 32'h0000_00c0; // idx 0x30
    localparam logic [31:0] PC_D     = 32'h0000_0100; // idx 0x40

    // one stimulus row plus the expected prediction for its lookup
    typedef struct packed {
        logic        lk;
        logic [31:0] lk_pc;
        logic        unc;
        logic        rs;
        logic [31:0] rs_pc;
        logic        rs_tk;
        logic        exp_taken;
        logic        exp_hit;
    } row_t;

    logic                clk;
    logic                rst;
    logic                lookup;
    logic [`BP_PC_W-1:0] lookup_pc;
    logic                uncond;
    logic                resolve;
    logic [`BP_PC_W-1:0] resolve_pc;
    logic                resolve_taken;
    logic                pred_valid;
    logic                pred_taken;
    logic                pred_hit;

    row_t rows [NUM_ROWS];

    // reference bht
    logic       model_vld [`BP_DEPTH];
    logic [1:0] model_ctr [`BP_DEPTH];

    // expectation for the prediction due at the next falling edge
    logic exp_valid;
    logic exp_taken;
    logic exp_hit;

    logic [31:0] seed;
    int          errors;
    int          checks;

    bpu_top UUT (
        .clk           (clk),
        .rst           (rst),
        .lookup        (lookup),
        .lookup_pc     (lookup_pc),
        .uncond        (uncond),
        .resolve       (resolve),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken),
        .pred_valid    (pred_valid),
        .pred_taken    (pred_taken),
        .pred_hit      (pred_hit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // {taken, hit} the model predicts for a pc
    function automatic logic [1:0] model_predict(input logic [31:0] pc, input logic unc);
        logic [`BP_IDX_W-1:0] idx;
        idx = pc[`BP_IDX_W+1:2];
        return {unc | (model_vld[idx] & model_ctr[idx][1]), model_vld[idx]};
    endfunction

    // saturating step toward the outcome or weak allocate on a fresh slot
    task automatic model_train(input logic [31:0] pc, input logic tk);
        logic [`BP_IDX_W-1:0] idx;
        idx = pc[`BP_IDX_W+1:2];
        if (!model_vld[idx]) begin
            model_ctr[idx] = tk ? 2'd2 : 2'd1;
        end else if (tk) begin
            model_ctr[idx] = (model_ctr[idx] == 2'd3) ? 2'd3 : model_ctr[idx] + 2'd1;
        end else begin
            model_ctr[idx] = (model_ctr[idx] == 2'd0) ? 2'd0 : model_ctr[idx] - 2'd1;
        end
        model_vld[idx] = 1'b1;
    endtask

    // row fields in order lk lk_pc unc rs rs_pc rs_tk exp_taken exp_hit
    task automatic load_table();
        rows[0]  = '{1'b1, PC_A, 1'b0, 1'b0, PC_0, 1'b0, 1'b0, 1'b0}; // cold miss
        rows[1]  = '{1'b1, PC_B, 1'b1, 1'b0, PC_0, 1'b0, 1'b1, 1'b0}; // jump on a miss
        rows[2]  = '{1'b0, PC_0, 1'b0, 1'b1, PC_A, 1'b1, 1'b0, 1'b0}; // A -> t
        rows[3]  = '{1'b1, PC_A, 1'b0, 1'b0, PC_0, 1'b0, 1'b1, 1'b1};
        rows[4]  = '{1'b0, PC_0, 1'b0, 1'b1, PC_B, 1'b0, 1'b0, 1'b0}; // B -> n
        rows[5]  = '{1'b1, PC_B, 1'b0, 1'b0, PC_0, 1'b0, 1'b0, 1'b1};
        rows[6]  = '{1'b1, PC_B, 1'b1, 1'b0, PC_0, 1'b0, 1'b1, 1'b1}; // jump on a hit
        rows[7]  = '{1'b0, PC_0, 1'b0, 1'b1, PC_A, 1'b1, 1'b0, 1'b0}; // A -> T
        rows[8]  = '{1'b0, PC_0, 1'b0, 1'b1, PC_A, 1'b1, 1'b0, 1'b0}; // stays T
        rows[9]  = '{1'b0, PC_0, 1'b0, 1'b1, PC_A, 1'b0, 1'b0, 1'b0}; // A -> t
        rows[10] = '{1'b1, PC_A, 1'b0, 1'b0, PC_0, 1'b0, 1'b1, 1'b1}; // still taken
        rows[11] = '{1'b0, PC_0, 1'b0, 1'b1, PC_A, 1'b0, 1'b0, 1'b0}; // A -> n
        rows[12] = '{1'b1, PC_A, 1'b0, 1'b0, PC_0, 1'b0, 1'b0, 1'b1};
        rows[13] = '{1'b0, PC_0, 1'b0, 1'b1, PC_B, 1'b0, 1'b0, 1'b0}; // B -> N
        rows[14] = '{1'b0, PC_0, 1'b0, 1'b1, PC_B, 1'b0, 1'b0, 1'b0}; // stays N
        rows[15] = '{1'b0, PC_0, 1'b0, 1'b1, PC_B, 1'b1, 1'b0, 1'b0}; // B -> n
        rows[16] = '{1'b1, PC_B, 1'b0, 1'b0, PC_0, 1'b0, 1'b0, 1'b1}; // still not taken
        rows[17] = '{1'b0, PC_0, 1'b0, 1'b1, PC_B, 1'b1, 1'b0, 1'b0}; // B -> t
        rows[18] = '{1'b1, PC_B, 1'b0, 1'b0, PC_0, 1'b0, 1'b1, 1'b1};
        rows[19] = '{1'b1, PC_A_HI, 1'b0, 1'b0, PC_0, 1'b0, 1'b0, 1'b1}; // sees A = n
        rows[20] = '{1'b0, PC_0, 1'b0, 1'b1, PC_A_LO, 1'b1, 1'b0, 1'b0}; // A -> t
        rows[21] = '{1'b1, PC_A_ALL, 1'b0, 1'b0, PC_0, 1'b0, 1'b1, 1'b1};
        rows[22] = '{1'b1, PC_C, 1'b0, 1'b1, PC_C, 1'b1, 1'b0, 1'b0}; // same edge sees old
        rows[23] = '{1'b1, PC_C, 1'b0, 1'b0, PC_0, 1'b0, 1'b1, 1'b1}; // next edge sees new
        rows[24] = '{1'b1, PC_C, 1'b0, 1'b1, PC_C, 1'b0, 1'b1, 1'b1}; // old t while C -> n
        rows[25] = '{1'b1, PC_D, 1'b1, 1'b0, PC_0, 1'b0, 1'b1, 1'b0};
        rows[26] = '{1'b1, PC_C, 1'b0, 1'b0, PC_0, 1'b0, 1'b0, 1'b1};
        rows[27] = '{1'b1, PC_D, 1'b0, 1'b1, PC_A, 1'b0, 1'b0, 1'b0}; // back to back
    endtask

    // random row on indexes 0x80..0x83 checked against the model
    task automatic random_row(output row_t s);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [1:0]  pred;
        seed = lcg_next(seed);
        r1 = seed;
        seed = lcg_next(seed);
        r2 = seed;
        s.lk    = r1[31] | r1[30]; // mostly lookups
        s.unc   = r1[29] & r1[28];
        s.rs    = r1[27] | r1[26];
        s.rs_tk = r1[25];
        s.lk_pc = {r2[31:10], 6'b100000, r1[24:23], r2[1:0]};
        s.rs_pc = {r2[21:0], 6'b100000, r1[22:21], r2[23:22]};
        pred = model_predict(s.lk_pc, s.unc);
        s.exp_taken = pred[1];
        s.exp_hit   = pred[0];
    endtask

    // drive a row at the falling edge and train the model for the next edge
    task automatic drive_step(input row_t s);
        lookup        = s.lk;
        lookup_pc     = s.lk_pc;
        uncond        = s.unc;
        resolve       = s.rs;
        resolve_pc    = s.rs_pc;
        resolve_taken = s.rs_tk;
        exp_valid = s.lk;
        // taken and hit hold when no lookup
        if (s.lk) begin
            exp_taken = s.exp_taken;
            exp_hit   = s.exp_hit;
        end
        if (s.rs) begin
            model_train(s.rs_pc, s.rs_tk);
        end
    endtask

    // previous row's prediction is stable since the rising edge
    task automatic check_pred();
        checks += 3;
        assert (pred_valid === exp_valid) else begin
            errors++;
            $display("[ERROR] %0t pred_valid expected %0b got %0b",
                     $time, exp_valid, pred_valid);
        end
        assert (pred_taken === exp_taken) else begin
            errors++;
            $display("[ERROR] %0t pred_taken expected %0b got %0b",
                     $time, exp_taken, pred_taken);
        end
        assert (pred_hit === exp_hit) else begin
            errors++;
            $display("[ERROR] %0t pred_hit expected %0b got %0b",
                     $time, exp_hit, pred_hit);
        end
    endtask

    initial begin
        row_t stim;
        clk           = 1'b0;
        rst           = 1'b1;
        lookup        = 1'b0;
        lookup_pc     = '0;
        uncond        = 1'b0;
        resolve       = 1'b0;
        resolve_pc    = '0;
        resolve_taken = 1'b0;
        exp_valid     = 1'b0;
        exp_taken     = 1'b0;
        exp_hit       = 1'b0;
        seed          = 32'h7e0eca4a;
        errors        = 0;
        checks        = 0;
        for (int k = 0; k < `BP_DEPTH; k++) begin
            model_vld[k] = 1'b0; // reset clears valid only
            model_ctr[k] = 2'd0;
        end
        load_table();

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // outputs cleared by reset
        checks += 3;
        assert (pred_valid === 1'b0) else begin
            errors++;
            $display("[ERROR] %0t pred_valid expected 0 got %0b", $time, pred_valid);
        end
        assert (pred_taken === 1'b0) else begin
            errors++;
            $display("[ERROR] %0t pred_taken expected 0 got %0b", $time, pred_taken);
        end
        assert (pred_hit === 1'b0) else begin
            errors++;
            $display("[ERROR] %0t pred_hit expected 0 got %0b", $time, pred_hit);
        end

        // directed phase
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            check_pred();
            drive_step(rows[i]);
        end

        // random phase
        for (int i = 0; i < NUM_RAND; i++) begin
            @(negedge clk);
            check_pred();
            random_row(stim);
            drive_step(stim);
        end

        // drain the last pulse then idle
        @(negedge clk);
        check_pred();
        stim = '0;
        drive_step(stim);
        @(negedge clk);
        check_pred();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the test sequence did not finish", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
